/* list.f */
+incdir+testbench
src/valu_pkg.sv
src/valu_cmd_queue.sv
src/valu_slice_seq.sv
src/valu_slice_alu.sv
src/valu_elem_assemble.sv
src/valu_lane_top.sv
testbench/tb_valu_lane.sv

/* src/valu_cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_cmd_queue (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     cmd_valid,
    input  wire valu_pkg::valu_cmd_t cmd,
    input  wire                     q_pop,
    output logic                    q_valid,
    output valu_pkg::valu_cmd_t     q_cmd,
    output logic                    cmd_credit
);
    import valu_pkg::*;

    valu_cmd_t            mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_CNT_W-1:0] count;

    assign q_valid    = (count != '0);
    assign q_cmd      = mem[rd_ptr];
    assign cmd_credit = q_pop;      // one credit back per entry leaving

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer must hold a credit to push
    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        cmd_valid |-> (count < CMD_DEPTH));

    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
        q_pop |-> q_valid);

endmodule

`default_nettype wire

/* src/valu_elem_assemble.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_elem_assemble (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire                           sres_valid,
    input  wire valu_pkg::valu_slice_res_t sres,
    output logic                          res_valid,
    output valu_pkg::valu_res_t           res
);
    import valu_pkg::*;

    logic [ELEM_W-1:0] elem_q;
    logic [ELEM_W-1:0] merged;
    logic              done;

    assign done = sres_valid && sres.last;

    always_comb begin
        merged = elem_q;
        merged[sres.idx * LANE_W +: LANE_W] = sres.data;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            elem_q    <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= done;
            if (sres_valid) begin
                elem_q <= sres.last ? '0 : merged;  // cleared so upper bits read zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            res.data <= merged;
            res.tag  <= sres.tag;
        end
    end

    // slices of one element arrive back to back
    a_elem_contig: assert property (@(posedge clk) disable iff (!resetn)
        (sres_valid && !sres.last) |=> (sres_valid && (sres.tag == $past(sres.tag))));

    // compare decision holds for the rest of the element
    a_cmp_stable: assert property (@(posedge clk) disable iff (!resetn)
        (sres_valid && !sres.last && (sres.cmp != UNDECIDED))
            |=> (sres_valid && (sres.cmp == $past(sres.cmp))));

endmodule

`default_nettype wire

/* src/valu_lane_top.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_lane_top (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     cmd_valid,
    input  wire valu_pkg::valu_cmd_t cmd,
    input  wire                     res_credit,
    output logic                    cmd_credit,
    output logic                    res_valid,
    output valu_pkg::valu_res_t     res
);
    import valu_pkg::*;

    logic            q_valid;
    valu_cmd_t       q_cmd;
    logic            q_pop;
    logic            slice_valid;
    valu_slice_t     slice;
    logic            sres_valid;
    valu_slice_res_t sres;

    valu_cmd_queue u_queue (
        .clk        (clk),
        .resetn     (resetn),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .q_pop      (q_pop),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .cmd_credit (cmd_credit)
    );

    valu_slice_seq u_seq (
        .clk         (clk),
        .resetn      (resetn),
        .q_valid     (q_valid),
        .q_cmd       (q_cmd),
        .res_valid   (res_valid),
        .res_credit  (res_credit),
        .q_pop       (q_pop),
        .slice_valid (slice_valid),
        .slice       (slice)
    );

    valu_slice_alu u_alu (
        .clk         (clk),
        .resetn      (resetn),
        .slice_valid (slice_valid),
        .slice       (slice),
        .sres_valid  (sres_valid),
        .sres        (sres)
    );

    valu_elem_assemble u_asm (
        .clk        (clk),
        .resetn     (resetn),
        .sres_valid (sres_valid),
        .sres       (sres),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

`default_nettype wire

/* src/valu_pkg.sv */
`default_nettype none

package valu_pkg;

    localparam int LANE_W      = 16;
    localparam int ELEM_W      = 64;
    localparam int MAX_SLICES  = ELEM_W / LANE_W;
    localparam int SLICE_IDX_W = 2;
    localparam int CMD_DEPTH   = 2;
    localparam int CMD_PTR_W   = 1;
    localparam int CMD_CNT_W   = 2;     // holds 0..CMD_DEPTH
    localparam int RES_CREDITS = 2;
    localparam int CRED_W      = 2;
    localparam int TAG_W       = 4;
    localparam int CPOP_W      = 7;     // up to 64 ones

    // funct6 codes of OPIVV and OPMVV do not overlap
    typedef enum logic [5:0] {
        VADD   = 6'b000000,
        VSUB   = 6'b000010,
        VRSUB  = 6'b000011,
        VMINU  = 6'b000100,
        VMIN   = 6'b000101,
        VMAXU  = 6'b000110,
        VMAX   = 6'b000111,
        VAND   = 6'b001001,
        VOR    = 6'b001010,
        VXOR   = 6'b001011,
        VCPOP  = 6'b010000,
        VMANDN = 6'b011000,
        VMAND  = 6'b011001,
        VMOR   = 6'b011010,
        VMXOR  = 6'b011011,
        VMORN  = 6'b011100,
        VMNAND = 6'b011101,
        VMNOR  = 6'b011110,
        VMXNOR = 6'b011111
    } valu_op_e;

    typedef enum logic [2:0] {
        E8  = 3'b000,
        E16 = 3'b001,
        E32 = 3'b010,
        E64 = 3'b011
    } sew_e;

    typedef enum logic [1:0] {
        UNDECIDED = 2'b00,
        VS2_LT    = 2'b01,
        VS2_GE    = 2'b10
    } cmp_state_e;

    typedef enum logic {
        IDLE,
        RUN
    } seq_state_e;

    typedef struct packed {
        valu_op_e          op;
        sew_e              sew;
        logic [ELEM_W-1:0] vs1;
        logic [ELEM_W-1:0] vs2;
        logic [TAG_W-1:0]  tag;
    } valu_cmd_t;

    typedef struct packed {
        valu_op_e               op;
        sew_e                   sew;
        logic [LANE_W-1:0]      a;      // vs2 slice
        logic [LANE_W-1:0]      b;      // vs1 slice
        logic [SLICE_IDX_W-1:0] idx;
        logic                   first;
        logic                   last;
        logic [TAG_W-1:0]       tag;
    } valu_slice_t;

    typedef struct packed {
        logic [LANE_W-1:0]      data;
        logic [SLICE_IDX_W-1:0] idx;
        logic                   last;
        cmp_state_e             cmp;
        logic [TAG_W-1:0]       tag;
    } valu_slice_res_t;

    typedef struct packed {
        logic [ELEM_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } valu_res_t;

endpackage

`default_nettype wire

/* src/valu_slice_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_slice_alu (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       slice_valid,
    input  wire valu_pkg::valu_slice_t slice,
    output logic                      sres_valid,
    output valu_pkg::valu_slice_res_t sres
);
    import valu_pkg::*;

    logic [LANE_W-1:0] a;
    logic [LANE_W-1:0] b;
    logic [LANE_W-1:0] sew_mask;
    logic [LANE_W-1:0] sgn_flip;
    logic [LANE_W-1:0] add_x;
    logic [LANE_W-1:0] add_y;
    logic [LANE_W-1:0] res_data;
    logic [LANE_W:0]   sum;
    logic              carry_in;
    logic              carry_q;
    logic              lt;
    logic              is_sub;
    logic              is_rsub;
    logic              is_signed;
    logic              is_minmax;
    cmp_state_e        cmp_q;
    cmp_state_e        cmp_prev;
    cmp_state_e        cmp_now;
    logic [CPOP_W-1:0] acc_q;
    logic [CPOP_W-1:0] acc_next;
    valu_slice_res_t   sres_d;

    // ones in a nibble
    function automatic logic [2:0] pop4(input logic [3:0] v);
        case (v)
            4'h0:                   return 3'd0;
            4'h1, 4'h2, 4'h4, 4'h8: return 3'd1;
            4'h7, 4'hb, 4'hd, 4'he: return 3'd3;
            4'hf:                   return 3'd4;
            default:                return 3'd2;
        endcase
    endfunction

    function automatic logic [3:0] pop8(input logic [7:0] v);
        return {1'b0, pop4(v[7:4])} + {1'b0, pop4(v[3:0])};
    endfunction

    assign a = slice.a;
    assign b = slice.b;

    always_comb begin
        sew_mask  = (slice.sew == E8) ? LANE_W'(8'hff) : '1;
        is_sub    = (slice.op == VSUB);
        is_rsub   = (slice.op == VRSUB);
        is_signed = (slice.op == VMIN) || (slice.op == VMAX);
        is_minmax = slice.op inside {VMINU, VMIN, VMAXU, VMAX};

        // subtrahend inverted with the +1 as first carry
        carry_in = slice.first ? (is_sub || is_rsub) : carry_q;
        add_x    = is_rsub ? b : a;
        add_y    = (is_sub ? ~b : (is_rsub ? ~a : b)) & sew_mask;
        sum      = {1'b0, add_x} + {1'b0, add_y} + {{LANE_W{1'b0}}, carry_in};

        // signed compare only on the top slice which comes first
        if (is_signed && slice.first) begin
            sgn_flip = (slice.sew == E8) ? LANE_W'(8'h80) : {1'b1, {(LANE_W-1){1'b0}}};
        end else begin
            sgn_flip = '0;
        end
        lt       = (a ^ sgn_flip) < (b ^ sgn_flip);
        cmp_prev = slice.first ? UNDECIDED : cmp_q;
        if ((cmp_prev == UNDECIDED) && (a != b)) begin
            cmp_now = lt ? VS2_LT : VS2_GE;
        end else begin
            cmp_now = cmp_prev;
        end

        acc_next = (slice.first ? '0 : acc_q) + CPOP_W'(pop8(a[15:8])) + CPOP_W'(pop8(a[7:0]));

        case (slice.op)
            VAND, VMAND:       res_data = a & b;
            VOR, VMOR:         res_data = a | b;
            VXOR, VMXOR:       res_data = a ^ b;
            VMNAND:            res_data = ~(a & b);
            VMANDN:            res_data = a & ~b;
            VMNOR:             res_data = ~(a | b);
            VMORN:             res_data = a | ~b;
            VMXNOR:            res_data = ~(a ^ b);
            VADD, VSUB, VRSUB: res_data = sum[LANE_W-1:0];
            VMINU, VMIN:       res_data = (cmp_now == VS2_GE) ? b : a;  // undecided means equal
            VMAXU, VMAX:       res_data = (cmp_now == VS2_LT) ? b : a;
            VCPOP:             res_data = slice.last ? LANE_W'(acc_next) : '0;
            default:           res_data = '0;
        endcase

        sres_d.data = res_data & sew_mask;
        sres_d.idx  = ((slice.op == VCPOP) && slice.last) ? '0 : slice.idx;  // total to slice 0
        sres_d.last = slice.last;
        sres_d.cmp  = is_minmax ? cmp_now : UNDECIDED;
        sres_d.tag  = slice.tag;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sres_valid <= 1'b0;
            carry_q    <= 1'b0;
            cmp_q      <= UNDECIDED;
            acc_q      <= '0;
        end else begin
            sres_valid <= slice_valid;
            if (slice_valid) begin
                carry_q <= (slice.sew == E8) ? sum[8] : sum[LANE_W];
                cmp_q   <= cmp_now;
                acc_q   <= acc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slice_valid) begin
            sres <= sres_d;
        end
    end

endmodule

`default_nettype wire

/* src/valu_slice_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_slice_seq (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     q_valid,
    input  wire valu_pkg::valu_cmd_t q_cmd,
    input  wire                     res_valid,
    input  wire                     res_credit,
    output logic                    q_pop,
    output logic                    slice_valid,
    output valu_pkg::valu_slice_t   slice
);
    import valu_pkg::*;

    seq_state_e             state;
    valu_cmd_t              cmd_q;
    logic [SLICE_IDX_W-1:0] slice_cnt;
    logic [SLICE_IDX_W-1:0] last_idx;
    logic [SLICE_IDX_W-1:0] cur_idx;
    logic [CRED_W-1:0]      cred_cnt;
    logic [CRED_W-1:0]      resv_cnt;   // elements holding a credit whose result is not out yet
    logic [ELEM_W-1:0]      vs1_m;
    logic [ELEM_W-1:0]      vs2_m;
    logic                   last_issue;
    logic                   msb_first;

    function automatic logic [ELEM_W-1:0] sew_mask(input sew_e s);
        case (s)
            E8:      return ELEM_W'(8'hff);
            E16:     return ELEM_W'(16'hffff);
            E32:     return ELEM_W'(32'hffff_ffff);
            default: return '1;
        endcase
    endfunction

    function automatic logic [SLICE_IDX_W-1:0] top_slice(input sew_e s);
        case (s)
            E32:     return SLICE_IDX_W'(1);
            E64:     return SLICE_IDX_W'(3);
            default: return '0;
        endcase
    endfunction

    assign slice_valid = (state == RUN);
    assign last_issue  = slice_valid && (slice_cnt == last_idx);
    // next head may start right behind the last slice
    assign q_pop = q_valid && (cred_cnt != '0) && ((state == IDLE) || last_issue);

    always_comb begin
        last_idx    = top_slice(cmd_q.sew);
        msb_first   = cmd_q.op inside {VMINU, VMIN, VMAXU, VMAX};
        cur_idx     = msb_first ? (last_idx - slice_cnt) : slice_cnt;
        vs1_m       = cmd_q.vs1 & sew_mask(cmd_q.sew);
        vs2_m       = cmd_q.vs2 & sew_mask(cmd_q.sew);
        slice.op    = cmd_q.op;
        slice.sew   = cmd_q.sew;
        slice.a     = vs2_m[cur_idx * LANE_W +: LANE_W];
        slice.b     = vs1_m[cur_idx * LANE_W +: LANE_W];
        slice.idx   = cur_idx;
        slice.first = (slice_cnt == '0);
        slice.last  = (slice_cnt == last_idx);
        slice.tag   = cmd_q.tag;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= IDLE;
            slice_cnt <= '0;
        end else if (q_pop) begin
            state     <= RUN;
            slice_cnt <= '0;
        end else if (last_issue) begin
            state <= IDLE;
        end else if (state == RUN) begin
            slice_cnt <= slice_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            cmd_q <= q_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cred_cnt <= CRED_W'(RES_CREDITS);
            resv_cnt <= '0;
        end else begin
            if (q_pop && !res_credit) begin
                cred_cnt <= cred_cnt - 1'b1;    // reserved at element start
            end else if (res_credit && !q_pop) begin
                cred_cnt <= cred_cnt + 1'b1;
            end
            if (q_pop && !res_valid) begin
                resv_cnt <= resv_cnt + 1'b1;
            end else if (res_valid && !q_pop) begin
                resv_cnt <= resv_cnt - 1'b1;
            end
        end
    end

    a_cred_bound: assert property (@(posedge clk) disable iff (!resetn)
        (cred_cnt <= RES_CREDITS) && ((cred_cnt + resv_cnt) <= RES_CREDITS));

    a_slice_reserved: assert property (@(posedge clk) disable iff (!resetn)
        slice_valid |-> (resv_cnt != '0));

endmodule

`default_nettype wire

/* testbench/valu_model.svh */
`ifndef VALU_MODEL_SVH
`define VALU_MODEL_SVH

// whole-element reference from the ISA rules

function automatic logic [63:0] width_mask(input sew_e sew);
    case (sew)
        E8:      return 64'h0000_0000_0000_00ff;
        E16:     return 64'h0000_0000_0000_ffff;
        E32:     return 64'h0000_0000_ffff_ffff;
        default: return '1;
    endcase
endfunction

function automatic int width_bits(input sew_e sew);
    return 8 << int'(sew);
endfunction

function automatic logic signed [63:0] sign_extend(input logic [63:0] v, input int w);
    logic signed [63:0] t;
    t = v << (64 - w);
    return t >>> (64 - w);  // arithmetic shift brings the sign bit back down
endfunction

function automatic logic [63:0] count_ones(input logic [63:0] v);
    logic [63:0] n;
    n = '0;
    for (int i = 0; i < 64; i++) begin
        n = n + v[i];
    end
    return n;
endfunction

function automatic logic [63:0] expected_result(input valu_op_e op, input sew_e sew,
                                                input logic [63:0] vs1, input logic [63:0] vs2);
    logic [63:0]        m;
    logic [63:0]        x;
    logic [63:0]        y;
    logic signed [63:0] sx;
    logic signed [63:0] sy;
    logic [63:0]        r;
    m  = width_mask(sew);
    x  = vs1 & m;
    y  = vs2 & m;
    sx = sign_extend(x, width_bits(sew));
    sy = sign_extend(y, width_bits(sew));
    case (op)
        VAND, VMAND: r = y & x;
        VOR, VMOR:   r = y | x;
        VXOR, VMXOR: r = y ^ x;
        VMNAND:      r = ~(y & x);
        VMANDN:      r = y & ~x;
        VMNOR:       r = ~(y | x);
        VMORN:       r = y | ~x;
        VMXNOR:      r = ~(y ^ x);
        VADD:        r = y + x;
        VSUB:        r = y - x;
        VRSUB:       r = x - y;
        VMINU:       r = (y < x) ? y : x;
        VMAXU:       r = (y > x) ? y : x;
        VMIN:        r = (sy < sx) ? y : x;
        VMAX:        r = (sy > sx) ? y : x;
        VCPOP:       r = count_ones(y);
        default:     r = 'x;
    endcase
    return r & m;   // wrap to SEW bits
endfunction

`endif

/* testbench/tb_valu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_valu_lane;
    import valu_pkg::*;

    `include "valu_model.svh"

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_CMDS    = 300;

    logic              clk;
    logic              resetn;
    logic              cmd_valid;
    valu_cmd_t         cmd;
    logic              res_credit;
    logic              cmd_credit;
    logic              res_valid;
    valu_res_t         res;

    logic [ELEM_W-1:0] exp_data_q[$];
    logic [TAG_W-1:0]  exp_tag_q[$];
    int                credit_due[$];   // cycle at which a result credit goes back
    int                errors;
    int                cycle_cnt;
    int                cmd_credits;
    int                sent_cnt;
    int                cmd_credit_pulses;
    int                res_cnt;
    int                res_credit_cnt;
    int                held_res_cnt;
    logic              hold_credits;
    logic [TAG_W-1:0]  next_tag;

    valu_op_e all_ops [19] = '{
        VADD, VSUB, VRSUB, VMINU, VMIN, VMAXU, VMAX, VAND, VOR, VXOR, VCPOP,
        VMANDN, VMAND, VMOR, VMXOR, VMORN, VMNAND, VMNOR, VMXNOR
    };

    valu_lane_top dut0 (
        .clk        (clk),
        .resetn     (resetn),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .res_credit (res_credit),
        .cmd_credit (cmd_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("error at %0t: timed out waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic wait_cmd_credit();
        int n;
        n = 0;
        while ((cmd_credits == 0) && (n < TIMEOUT_CYCLES)) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (cmd_credits == 0) begin
            timeout_fail("a command credit");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (((exp_data_q.size() != 0) || (credit_due.size() != 0)) && (n < TIMEOUT_CYCLES)) begin
            @(posedge clk);
            #1;
            n++;
        end
        if ((exp_data_q.size() != 0) || (credit_due.size() != 0)) begin
            timeout_fail("the remaining results");
        end
    endtask

    function automatic valu_cmd_t make_cmd(input valu_op_e op, input sew_e sew);
        valu_cmd_t c;
        int        w;
        w     = width_bits(sew);
        c.op  = op;
        c.sew = sew;
        c.tag = '0;
        c.vs2 = {$urandom, $urandom};
        c.vs1 = {$urandom, $urandom};
        case ($urandom % 5)
            1: c.vs1 = {c.vs2[63:16], c.vs1[15:0]};     // equal high slices
            2: c.vs1 = c.vs2 ^ (64'd1 << (w - 1));      // only the sign bits differ
            3: c.vs1 = c.vs2;
            4: begin
                c.vs2 = '1;                             // carry runs through every slice
                c.vs1 = 64'(1 + ($urandom % 3));
            end
            default: ;
        endcase
        return c;
    endfunction

    task automatic send_cmd(input valu_cmd_t c);
        wait_cmd_credit();
        c.tag     = next_tag;
        next_tag  = next_tag + 1'b1;
        cmd       = c;
        cmd_valid = 1'b1;
        cmd_credits--;
        sent_cnt++;
        exp_data_q.push_back(expected_result(c.op, c.sew, c.vs1, c.vs2));
        exp_tag_q.push_back(c.tag);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // consumer returns one credit per due entry
    always @(posedge clk) begin
        #1;
        res_credit = 1'b0;
        if (!hold_credits && (credit_due.size() > 0) && (credit_due[0] <= cycle_cnt)) begin
            res_credit = 1'b1;
            void'(credit_due.pop_front());
        end
    end

    // outputs sampled mid cycle
    always @(negedge clk) begin
        if (resetn) begin
            if (cmd_credit) begin
                cmd_credits++;
                cmd_credit_pulses++;
                if (cmd_credit_pulses > sent_cnt) begin
                    errors++;
                    $display("error at %0t: more cmd_credit pulses than commands sent", $time);
                end
            end
            if (res_credit) begin
                res_credit_cnt++;
            end
            if (res_valid) begin
                res_cnt++;
                if (hold_credits) begin
                    held_res_cnt++;
                end
                if ((res_cnt - res_credit_cnt) > RES_CREDITS) begin
                    errors++;
                    $display("error at %0t: res_valid raised without a result credit", $time);
                end
                if (exp_data_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: result arrived with no command outstanding", $time);
                end else begin
                    check_value("res.data", exp_data_q.pop_front(), res.data);
                    check_value("res.tag", exp_tag_q.pop_front(), res.tag);
                end
                credit_due.push_back(cycle_cnt + int'($urandom % 6));
            end
        end
    end

    initial begin
        resetn            = 1'b0;
        cmd_valid         = 1'b0;
        cmd               = '0;
        res_credit        = 1'b0;
        hold_credits      = 1'b0;
        next_tag          = '0;
        errors            = 0;
        cycle_cnt         = 0;
        cmd_credits       = CMD_DEPTH;
        sent_cnt          = 0;
        cmd_credit_pulses = 0;
        res_cnt           = 0;
        res_credit_cnt    = 0;
        held_res_cnt      = 0;
        void'($urandom(91532));

        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        repeat (8) @(posedge clk);  // quiet window where nothing may come out
        #1;

        // only RES_CREDITS results while the consumer holds back
        hold_credits = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_cmd(make_cmd(all_ops[$urandom % 19], sew_e'($urandom % 4)));
        end
        repeat (40) @(posedge clk);
        #1;
        check_value("held res_valid count", RES_CREDITS, held_res_cnt);
        hold_credits = 1'b0;

        foreach (all_ops[i]) begin
            for (int s = 0; s < 4; s++) begin
                send_cmd(make_cmd(all_ops[i], sew_e'(s)));
            end
        end

        for (int i = 0; i < RANDOM_CMDS; i++) begin
            send_cmd(make_cmd(all_ops[$urandom % 19], sew_e'($urandom % 4)));
            repeat ($urandom % 3) begin
                @(posedge clk);
                #1;
            end
        end

        wait_drained();
        repeat (2) @(posedge clk);
        #1;
        check_value("result count", sent_cnt, res_cnt);
        check_value("cmd credits", CMD_DEPTH, cmd_credits);
        finish_run();
    end

endmodule

`default_nettype wire
